//--- rtl/avionics_settings.svh
////////////////////
// Avionics settings
// Clock rate, frame timing, ESC limits and arm switch constants
////////////////////
`ifndef AVIONICS_SETTINGS_SVH
`define AVIONICS_SETTINGS_SVH

// Timebase
`define AV_CLK_PER_US   4
`define AV_US_PER_MS    1000

// Radio and ESC channels
`define AV_CHANNELS     8
`define AV_WIDTH_BITS   11
`define AV_FRAME_US     4000
`define AV_ESC_MIN_US   1000
`define AV_ESC_MAX_US   2000

// Arm switch on radio channel 4
`define AV_ARM_CHANNEL  4
`define AV_ARM_HOLD_MS  3

`define AV_STAMP_BITS   24

`endif

//--- rtl/avionics_pkg.sv
////////////////////
// Avionics package
// Radio word type, read as a width or as a switch
////////////////////
`default_nettype none

`include "avionics_settings.svh"

package avionics_pkg;

  // Switch reading of a pulse width
  // Position 1 low, 2 middle, 3 high
  typedef struct packed {
    logic [1:0]                  position;
    logic [`AV_WIDTH_BITS-3:0]   fine;
  } switch_view_s;

  // One measured radio channel
  typedef union packed {
    logic [`AV_WIDTH_BITS-1:0]   width;
    switch_view_s                sw;
  } radio_word_u;

  // All channels, channel 0 in the low bits
  typedef radio_word_u [`AV_CHANNELS-1:0] radio_words_t;

endpackage

`default_nettype wire

//--- rtl/tick_timer.sv
////////////////////
// Tick timer
// One-cycle microsecond and millisecond strobes from clk
////////////////////
`default_nettype none

`include "avionics_settings.svh"

module tick_timer (
  input  wire  clk,
  input  wire  reset,
  output logic us_tick,
  output logic ms_tick
);

  localparam int US_BITS = $clog2(`AV_CLK_PER_US);
  localparam int MS_BITS = $clog2(`AV_US_PER_MS);
  localparam logic [US_BITS-1:0] US_LAST = US_BITS'(`AV_CLK_PER_US - 1);
  localparam logic [MS_BITS-1:0] MS_LAST = MS_BITS'(`AV_US_PER_MS - 1);

  logic [US_BITS-1:0] us_cnt;
  logic [MS_BITS-1:0] ms_cnt;
  logic               us_wrap;

  // Last clk of each microsecond
  assign us_wrap = (us_cnt == US_LAST);

  always_ff @(posedge clk) begin
    if (reset) begin
      us_cnt  <= '0;
      ms_cnt  <= '0;
      us_tick <= 1'b0;
      ms_tick <= 1'b0;
    end else begin
      us_cnt  <= us_wrap ? '0 : us_cnt + 1'b1;
      us_tick <= us_wrap;
      // Millisecond strobe rides on the closing us strobe
      ms_tick <= us_wrap && (ms_cnt == MS_LAST);
      if (us_wrap) begin
        ms_cnt <= (ms_cnt == MS_LAST) ? '0 : ms_cnt + 1'b1;
      end
    end
  end

  a_ms_on_us: assert property (@(posedge clk) disable iff (reset) ms_tick |-> us_tick);

endmodule

`default_nettype wire

//--- rtl/pwm_capture.sv
////////////////////
// PWM capture
// Measures the high time of eight radio pulses in microseconds
////////////////////
`default_nettype none

`include "avionics_settings.svh"

module pwm_capture (
  input  wire                        clk,
  input  wire                        reset,
  input  wire                        us_tick,
  input  wire  [`AV_CHANNELS-1:0]    radio_sig,
  output avionics_pkg::radio_words_t radio_val
);

  localparam int N = `AV_CHANNELS;
  localparam int W = `AV_WIDTH_BITS;
  localparam logic [W-1:0] CNT_MAX = '1;

  // Two-flop synchronizer, then previous level for edge detect
  logic [N-1:0]        sync1;
  logic [N-1:0]        sync2;
  logic [N-1:0]        prev;
  logic [N-1:0]        fall;

  // Running width per channel
  logic [N-1:0][W-1:0] cnt;

  assign fall = prev & ~sync2;

  always_ff @(posedge clk) begin
    if (reset) begin
      sync1     <= '0;
      sync2     <= '0;
      prev      <= '0;
      cnt       <= '0;
      radio_val <= '0;
    end else begin
      sync1 <= radio_sig;
      sync2 <= sync1;
      prev  <= sync2;
      for (int i = 0; i < N; i++) begin
        if (fall[i]) begin
          // Pulse over, publish its width
          radio_val[i].width <= cnt[i];
          cnt[i]             <= '0;
        end else if (sync2[i] && us_tick && (cnt[i] != CNT_MAX)) begin
          cnt[i] <= cnt[i] + 1'b1;
        end
      end
    end
  end

  // Counter sticks at full scale for long pulses
  for (genvar g = 0; g < N; g++) begin : g_sat_check
    a_cnt_saturates: assert property (
      @(posedge clk) disable iff (reset)
      (cnt[g] == CNT_MAX) && sync2[g] |=> (cnt[g] == CNT_MAX)
    );
  end

endmodule

`default_nettype wire

//--- rtl/arm_switch.sv
////////////////////
// Arm switch
// Debounced arm flag from the radio arm channel
////////////////////
`default_nettype none

`include "avionics_settings.svh"

module arm_switch (
  input  wire                        clk,
  input  wire                        reset,
  input  wire                        ms_tick,
  input  avionics_pkg::radio_words_t radio_val,
  output logic                       arm_flag
);

  localparam int HOLD_BITS = $clog2(`AV_ARM_HOLD_MS + 1);
  localparam logic [HOLD_BITS-1:0] HOLD_LAST = HOLD_BITS'(`AV_ARM_HOLD_MS - 1);
  localparam logic [1:0] POS_HIGH = 2'd3;

  logic [HOLD_BITS-1:0] hold_cnt;
  logic                 switch_high;

  // Top bits of the width give the stick position
  assign switch_high = (radio_val[`AV_ARM_CHANNEL].sw.position == POS_HIGH);

  always_ff @(posedge clk) begin
    if (reset) begin
      hold_cnt <= '0;
      arm_flag <= 1'b0;
    end else if (ms_tick) begin
      if (!switch_high) begin
        // Low, middle or mid-travel drops the flag at once
        hold_cnt <= '0;
        arm_flag <= 1'b0;
      end else if (hold_cnt == HOLD_LAST) begin
        arm_flag <= 1'b1;
      end else begin
        hold_cnt <= hold_cnt + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/board_sequencer.sv
////////////////////
// Board sequencer
// Board state machine, motor arm toggle, timestamp and status LEDs
////////////////////
`default_nettype none

`include "avionics_settings.svh"

module board_sequencer (
  input  wire                       clk,
  input  wire                       reset,
  input  wire                       ms_tick,
  input  wire                       shutdown_btn,
  input  wire                       arm_flag,
  output logic                      esc_enable,
  output logic [7:0]                led,
  output logic [`AV_STAMP_BITS-1:0] timestamp
);

  // Board states
  localparam logic [1:0] ST_IDLE     = 2'd0;
  localparam logic [1:0] ST_STARTUP  = 2'd1;
  localparam logic [1:0] ST_RUNNING  = 2'd2;
  localparam logic [1:0] ST_SHUTDOWN = 2'd3;

  logic [1:0] state;
  logic [1:0] state_next;
  logic       btn_sync1;
  logic       btn_sync2;
  logic       btn_prev;
  logic       btn_rise;
  logic       arm_prev;
  logic       motor_armed;

  assign btn_rise = btn_sync2 && !btn_prev;

  always_comb begin
    state_next = state;
    case (state)
      ST_IDLE:     state_next = ST_STARTUP;
      ST_STARTUP:  state_next = ST_RUNNING;
      // Only a button press leaves running
      ST_RUNNING:  if (btn_rise) state_next = ST_SHUTDOWN;
      ST_SHUTDOWN: state_next = ST_IDLE;
      default:     state_next = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state       <= ST_IDLE;
      btn_sync1   <= 1'b0;
      btn_sync2   <= 1'b0;
      btn_prev    <= 1'b0;
      arm_prev    <= 1'b0;
      motor_armed <= 1'b0;
      timestamp   <= '0;
    end else begin
      state     <= state_next;
      btn_sync1 <= shutdown_btn;
      btn_sync2 <= btn_sync1;
      btn_prev  <= btn_sync2;
      arm_prev  <= arm_flag;
      // Each arm flag rise flips the motors while running
      if (state != ST_RUNNING) begin
        motor_armed <= 1'b0;
      end else if (arm_flag && !arm_prev) begin
        motor_armed <= !motor_armed;
      end
      // Millisecond count since running began
      if (state != ST_RUNNING) begin
        timestamp <= '0;
      end else if (ms_tick) begin
        timestamp <= timestamp + 1'b1;
      end
    end
  end

  assign esc_enable = (state == ST_RUNNING) && motor_armed;
  assign led        = {state, motor_armed, timestamp[4:0]};

  a_enable_running: assert property (@(posedge clk) disable iff (reset)
    esc_enable |-> (state == ST_RUNNING) && ($past(state) == ST_RUNNING));
  a_shutdown_once: assert property (@(posedge clk) disable iff (reset)
    (state == ST_SHUTDOWN) |=> (state == ST_IDLE));

endmodule

`default_nettype wire

//--- rtl/esc_pwm.sv
////////////////////
// ESC PWM
// Frame-based eight-channel ESC pulses, clamped and gated by arm state
////////////////////
`default_nettype none

`include "avionics_settings.svh"

module esc_pwm (
  input  wire                        clk,
  input  wire                        reset,
  input  wire                        us_tick,
  input  wire                        esc_enable,
  input  avionics_pkg::radio_words_t radio_val,
  output logic [`AV_CHANNELS-1:0]    esc_sig
);

  localparam int N = `AV_CHANNELS;
  localparam int W = `AV_WIDTH_BITS;
  localparam int FRAME_BITS = $clog2(`AV_FRAME_US);
  localparam logic [FRAME_BITS-1:0] FRAME_LAST = FRAME_BITS'(`AV_FRAME_US - 1);
  localparam logic [W-1:0] ESC_MIN = W'(`AV_ESC_MIN_US);
  localparam logic [W-1:0] ESC_MAX = W'(`AV_ESC_MAX_US);

  logic [FRAME_BITS-1:0] frame_cnt;
  logic                  frame_start;
  logic                  frame_live;
  logic [N-1:0][W-1:0]   width_q;
  logic [N-1:0]          pulse_on;

  assign frame_start = us_tick && (frame_cnt == FRAME_LAST);

  always_ff @(posedge clk) begin
    if (reset) begin
      frame_cnt  <= '0;
      frame_live <= 1'b0;
    end else begin
      if (us_tick) begin
        frame_cnt <= (frame_cnt == FRAME_LAST) ? '0 : frame_cnt + 1'b1;
      end
      // Disarm kills the rest of the frame
      if (!esc_enable) begin
        frame_live <= 1'b0;
      end else if (frame_start) begin
        frame_live <= 1'b1;
      end
    end
  end

  // Widths sampled once per frame, clamped to ESC range
  always_ff @(posedge clk) begin
    if (frame_start) begin
      for (int i = 0; i < N; i++) begin
        if (radio_val[i].width < ESC_MIN) begin
          width_q[i] <= ESC_MIN;
        end else if (radio_val[i].width > ESC_MAX) begin
          width_q[i] <= ESC_MAX;
        end else begin
          width_q[i] <= radio_val[i].width;
        end
      end
    end
  end

  always_comb begin
    for (int i = 0; i < N; i++) begin
      pulse_on[i] = (FRAME_BITS'(width_q[i]) > frame_cnt);
    end
  end

  // Enable also gates directly so a drop silences at once
  assign esc_sig = (frame_live && esc_enable) ? pulse_on : '0;

  a_silent_disarmed: assert property (@(posedge clk) disable iff (reset)
    !esc_enable |-> (esc_sig == '0) ##1 (esc_sig == '0));

endmodule

`default_nettype wire

//--- rtl/avionics_top.sv
////////////////////
// Avionics top
// Radio capture, board sequencing and ESC outputs
////////////////////
`default_nettype none

`include "avionics_settings.svh"

module avionics_top (
  input  wire                        clk,
  input  wire                        reset,
  input  wire                        shutdown_btn,
  input  wire  [`AV_CHANNELS-1:0]    radio_sig,
  output logic [`AV_CHANNELS-1:0]    esc_sig,
  output logic [7:0]                 led,
  output logic [`AV_STAMP_BITS-1:0]  timestamp
);

  logic                       us_tick;
  logic                       ms_tick;
  logic                       arm_flag;
  logic                       esc_enable;
  // Measured radio widths, all channels
  avionics_pkg::radio_words_t radio_val;

  tick_timer u_tick_timer (
    .clk     (clk),
    .reset   (reset),
    .us_tick (us_tick),
    .ms_tick (ms_tick)
  );

  pwm_capture u_pwm_capture (
    .clk       (clk),
    .reset     (reset),
    .us_tick   (us_tick),
    .radio_sig (radio_sig),
    .radio_val (radio_val)
  );

  arm_switch u_arm_switch (
    .clk       (clk),
    .reset     (reset),
    .ms_tick   (ms_tick),
    .radio_val (radio_val),
    .arm_flag  (arm_flag)
  );

  board_sequencer u_board_sequencer (
    .clk          (clk),
    .reset        (reset),
    .ms_tick      (ms_tick),
    .shutdown_btn (shutdown_btn),
    .arm_flag     (arm_flag),
    .esc_enable   (esc_enable),
    .led          (led),
    .timestamp    (timestamp)
  );

  // Radio widths go straight to the motors, no control law yet
  esc_pwm u_esc_pwm (
    .clk        (clk),
    .reset      (reset),
    .us_tick    (us_tick),
    .esc_enable (esc_enable),
    .radio_val  (radio_val),
    .esc_sig    (esc_sig)
  );

endmodule

`default_nettype wire

//--- dv/avionics_tb.sv
////////////////////
// Avionics testbench
// Radio pulses, arm switch and shutdown button against the flight-board core
////////////////////
`default_nettype none

`include "avionics_settings.svh"

module avionics_tb;

  localparam int N = `AV_CHANNELS;
  localparam int CLK_US = `AV_CLK_PER_US;
  localparam int FRAME_CLK = `AV_FRAME_US * `AV_CLK_PER_US;
  // Radio frame of 2500 us, longer than any test pulse
  localparam int RADIO_CLK = 2500 * `AV_CLK_PER_US;
  localparam int ARM_CH = `AV_ARM_CHANNEL;

  logic                      clk;
  logic                      reset;
  logic                      shutdown_btn;
  logic [N-1:0]              radio_sig;
  logic [N-1:0]              esc_sig;
  logic [7:0]                led;
  logic [`AV_STAMP_BITS-1:0] timestamp;

  // Pulse width in us per channel, read by the radio generator
  int radio_width [N];
  // Measured ESC high time in clocks
  int high_clk [N];
  int radio_frames;
  int errors;
  int checks;
  int tests;
  int err_mark;
  int seed;
  int ts_start;

  avionics_top UUT (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic check_range(input string name, input int lo, input int hi, input int actual);
    checks++;
    assert (actual >= lo && actual <= hi) else begin
      if (lo == hi)
        $display("** Error at %0t: %s expected %0d, got %0d", $time, name, lo, actual);
      else
        $display("** Error at %0t: %s expected %0d..%0d, got %0d", $time, name, lo, hi, actual);
      errors++;
    end
  endtask

  // Masked LED bits reaching a value
  task automatic wait_led(input logic [7:0] mask, input logic [7:0] value, input int limit);
    int n;
    n = 0;
    while ((led & mask) != value && n < limit) begin
      @(negedge clk);
      n++;
    end
    if ((led & mask) != value) begin
      $display("Timeout at %0t: led never read %02h under mask %02h", $time, value, mask);
      errors++;
    end
  endtask

  task automatic wait_radio_frames(input int count);
    int n;
    int target;
    n = 0;
    target = radio_frames + count;
    while (radio_frames < target && n < (count + 1) * RADIO_CLK) begin
      @(negedge clk);
      n++;
    end
    if (radio_frames < target) begin
      $display("Timeout at %0t: radio generator stalled", $time);
      errors++;
    end
  endtask

  // Switch low long enough to drop the flag, then high until the motor bit flips
  task automatic flip_arm(input logic expected);
    radio_width[ARM_CH] = 1000;
    wait_radio_frames(3);
    // Falling flag leaves the motor bit alone
    check_range("led[5]", int'(!expected), int'(!expected), int'(led[5]));
    radio_width[ARM_CH] = 2000;
    wait_led(8'h20, {2'b00, expected, 5'b0}, 8 * RADIO_CLK);
  endtask

  // High time of each ESC output over one whole frame
  task automatic measure_esc_frame();
    int n;
    n = 0;
    for (int i = 0; i < N; i++) begin
      high_clk[i] = 0;
    end
    // Skip a frame already under way
    while (esc_sig != '0 && n < 3 * FRAME_CLK) begin
      @(negedge clk);
      n++;
    end
    while (esc_sig == '0 && n < 3 * FRAME_CLK) begin
      @(negedge clk);
      n++;
    end
    while (esc_sig != '0 && n < 3 * FRAME_CLK) begin
      for (int i = 0; i < N; i++) begin
        high_clk[i] += int'(esc_sig[i]);
      end
      @(negedge clk);
      n++;
    end
    if (n >= 3 * FRAME_CLK) begin
      $display("Timeout at %0t: no complete ESC frame seen", $time);
      errors++;
    end
  endtask

  // Capture saturates at full scale, then the ESC range applies
  function automatic int esc_expected(input int w);
    int v;
    v = (w > 2047) ? 2047 : w;
    if (v < `AV_ESC_MIN_US) v = `AV_ESC_MIN_US;
    if (v > `AV_ESC_MAX_US) v = `AV_ESC_MAX_US;
    return v;
  endfunction

  task automatic end_test(input string name);
    tests++;
    if (errors == err_mark) begin
      $display("Test %0d %s: pass", tests, name);
    end else begin
      $display("Test %0d %s: FAIL, %0d errors", tests, name, errors - err_mark);
    end
    err_mark = errors;
  endtask

  // Output rules that hold on every cycle
  always @(negedge clk) begin
    if (!reset) begin
      // Motors quiet unless running and armed
      if (led[7:6] != 2'd2 || !led[5]) begin
        assert (esc_sig == '0) else begin
          $display("** Error at %0t: esc_sig expected 00, got %02h", $time, esc_sig);
          errors++;
        end
      end
      assert (led[4:0] == timestamp[4:0]) else begin
        $display("** Error at %0t: led[4:0] expected %02h, got %02h",
                 $time, timestamp[4:0], led[4:0]);
        errors++;
      end
      // Idle and startup hold the timestamp at zero
      if (led[7:6] == 2'd0 || led[7:6] == 2'd1) begin
        assert (timestamp == '0) else begin
          $display("** Error at %0t: timestamp expected 0, got %0d", $time, timestamp);
          errors++;
        end
      end
    end
  end

  // Radio receiver, all channels rise together each frame
  initial begin
    int w [N];
    radio_sig = '0;
    radio_frames = 0;
    forever begin
      @(posedge clk);
      #1;
      for (int i = 0; i < N; i++) begin
        w[i] = radio_width[i] * CLK_US;
      end
      radio_sig = '1;
      for (int c = 1; c < RADIO_CLK; c++) begin
        @(posedge clk);
        #1;
        for (int i = 0; i < N; i++) begin
          if (c == w[i]) radio_sig[i] = 1'b0;
        end
      end
      radio_frames++;
    end
  end

  initial begin
    seed = 32'h076a0d75;
    errors = 0;
    checks = 0;
    tests = 0;
    err_mark = 0;
    reset = 1'b1;
    shutdown_btn = 1'b0;
    for (int i = 0; i < N; i++) begin
      radio_width[i] = 1000;
    end
    repeat (16) @(posedge clk);
    #1;
    reset = 1'b0;

    // Idle, then startup, then running
    @(posedge clk);
    #1;
    check_range("led[7:6]", 1, 1, int'(led[7:6]));
    @(posedge clk);
    #1;
    check_range("led[7:6]", 2, 2, int'(led[7:6]));
    // Two unarmed frames
    repeat (2 * FRAME_CLK) @(negedge clk);
    end_test("bring-up");

    flip_arm(1'b1);
    check_range("led[5]", 1, 1, int'(led[5]));
    flip_arm(1'b0);
    check_range("led[5]", 0, 0, int'(led[5]));
    end_test("arm toggle");

    flip_arm(1'b1);
    for (int r = 0; r < 4; r++) begin
      // Arm switch stays high so the motors stay armed
      for (int i = 0; i < N; i++) begin
        radio_width[i] = (i == ARM_CH) ? 2000 : 900 + int'({$random(seed)} % 1201);
      end
      // Old widths may fill one radio frame before the new ones land
      wait_radio_frames(2);
      measure_esc_frame();
      for (int i = 0; i < N; i++) begin
        check_range($sformatf("esc_sig[%0d] width us", i), esc_expected(radio_width[i]) - 1,
                    esc_expected(radio_width[i]) + 1, high_clk[i] / CLK_US);
      end
    end
    end_test("pass-through");

    ts_start = int'(timestamp);
    repeat (5 * `AV_US_PER_MS * CLK_US) @(negedge clk);
    check_range("timestamp step", 4, 6, int'(timestamp) - ts_start);
    end_test("timestamp");

    @(posedge clk);
    #1;
    shutdown_btn = 1'b1;
    wait_led(8'hC0, 8'hC0, 16);
    @(negedge clk);
    check_range("led[7:6]", 0, 0, int'(led[7:6]));
    check_range("led[5]", 0, 0, int'(led[5]));
    check_range("timestamp", 0, 0, int'(timestamp));
    @(negedge clk);
    check_range("led[7:6]", 1, 1, int'(led[7:6]));
    @(negedge clk);
    check_range("led[7:6]", 2, 2, int'(led[7:6]));
    @(posedge clk);
    #1;
    shutdown_btn = 1'b0;
    // Running again but disarmed
    repeat (2 * FRAME_CLK) @(negedge clk);
    flip_arm(1'b1);
    measure_esc_frame();
    check_range($sformatf("esc_sig[%0d] width us", ARM_CH), 1999, 2001,
                high_clk[ARM_CH] / CLK_US);
    end_test("shutdown cycle");

    $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sim.f
+incdir+rtl
rtl/avionics_pkg.sv
rtl/tick_timer.sv
rtl/pwm_capture.sv
rtl/arm_switch.sv
rtl/board_sequencer.sv
rtl/esc_pwm.sv
rtl/avionics_top.sv
dv/avionics_tb.sv

//--- Makefile
# Verilator simulation of the flight-board core
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = avionics_tb
FILELIST  = sim.f
OBJ_DIR   = obj_dir
PASS_MSG  = No errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build and run the testbench, fails unless the pass message is printed"
	@echo "  clean  remove the Verilator build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
